// File: Makefile
SIM      = verilator
TOP      = dodge_game_tb
FILELIST = compile.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: compile.f
hw/dodge_pkg.sv
hw/playfield_if.sv
hw/game_tick_gen.sv
hw/player_ctrl.sv
hw/drop_field.sv
hw/game_fsm.sv
hw/matrix_scan.sv
hw/dodge_game_top.sv
dv/dodge_game_tb.sv

// File: dv/dodge_game_tb.sv
`timescale 1ns/1ns

module dodge_game_tb;

	localparam int DIV [4] = '{2, 4, 16, 64}; // scan, move, drop, second
	localparam int K_FIX = 0;
	localparam int K_RAND = 1;
	localparam int K_CHASE = 2;
	localparam int K_DODGE = 3;
	localparam int K_RST = 4;

	typedef struct {
		int kind;
		logic l;
		logic r;
		int hold; // cycles or the limit for chase and dodge
		int col; // -1 skips the column check
		dodge_pkg::game_state_t pic; // st_play checks no picture
	} step_t;

	logic CLK;
	logic reset;
	logic left;
	logic right;
	logic [2:0] row_sel;
	logic [7:0] data_r;
	logic [7:0] data_b;
	logic [5:0] elapsed_sec;
	logic [2:0] light;

	step_t steps [$];
	string kind_names [5] = '{"fixed", "random", "chase", "dodge", "reset"};
	int errors = 0;
	int checks = 0;
	int dot;

	// reference model state
	logic [7:0] m_act;
	logic [2:0] m_row [8];
	logic [7:0] m_lfsr;
	logic [2:0] m_col;
	int m_life;
	int m_sec;
	dodge_pkg::game_state_t m_state;
	logic m_hit;
	logic [3:0] m_tick;
	int m_cnt [4];
	logic [2:0] m_rsel;
	logic [7:0] m_dr;
	logic [7:0] m_db;

	dodge_game_top #(
		.SCAN_DIV(DIV[0]),
		.MOVE_DIV(DIV[1]),
		.DROP_DIV(DIV[2]),
		.SEC_DIV(DIV[3])
	) i_dut (
		.CLK(CLK),
		.reset(reset),
		.left(left),
		.right(right),
		.row_sel(row_sel),
		.data_r(data_r),
		.data_b(data_b),
		.elapsed_sec(elapsed_sec),
		.light(light)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	//////////////////////////////////////////////////
	// reference model updated once per clock edge

	always @(posedge CLK)
	begin : model
		dodge_pkg::game_state_t st_old;
		logic [2:0] rn;
		logic hit_n;
		if (reset)
		begin
			m_act = '0;
			m_lfsr = dodge_pkg::RND_SEED;
			m_col = '0;
			m_life = dodge_pkg::LIFE_INIT;
			m_sec = 0;
			m_state = dodge_pkg::st_play;
			m_hit = 1'b0;
			m_tick = '0;
			m_rsel = '0;
			m_dr = '1;
			m_db = '1;
			m_cnt = '{0, 0, 0, 0};
		end
		else
		begin
			st_old = m_state;
			hit_n = 1'b0;
			if (m_tick[0])
			begin
				rn = m_rsel + 3'd1; // row data uses the state before this edge
				m_rsel = rn;
				m_dr = '1;
				m_db = '1;
				if (st_old == dodge_pkg::st_won)
				begin
					m_dr = dodge_pkg::WIN_PIC[rn];
					m_db = dodge_pkg::WIN_PIC[rn];
				end
				else if (st_old == dodge_pkg::st_lost)
					m_dr = dodge_pkg::LOSS_PIC[rn];
				else
				begin
					for (int c = 0; c < 8; c++)
						if (m_act[c] && m_row[c] == rn)
							m_dr[c] = 1'b0;
					if (rn == dodge_pkg::PLAYER_ROW)
						m_db[m_col] = 1'b0;
				end
			end
			if (st_old == dodge_pkg::st_play)
			begin
				if (m_hit && m_life == 1)
					m_state = dodge_pkg::st_lost; // loss first
				else if (m_tick[3] && m_sec == int'(dodge_pkg::WIN_SECONDS) - 1)
					m_state = dodge_pkg::st_won;
				if (m_hit)
					m_life--;
				if (m_tick[3])
					m_sec++;
			end
			if (m_tick[2] && st_old == dodge_pkg::st_play)
			begin
				for (int c = 0; c < 8; c++)
				begin
					if (m_act[c] && m_row[c] == dodge_pkg::PLAYER_ROW)
					begin
						m_act[c] = 1'b0;
						hit_n = hit_n | (int'(m_col) == c);
					end
					else if (m_act[c])
						m_row[c] = m_row[c] + 3'd1;
				end
				// galois step for x^8+x^6+x^5+x^4+1
				m_lfsr = m_lfsr[0] ? ((m_lfsr >> 1) ^ 8'hB8) : (m_lfsr >> 1);
				if (m_lfsr[7:6] == 2'b11 && !m_act[m_lfsr[2:0]])
				begin
					m_act[m_lfsr[2:0]] = 1'b1;
					m_row[m_lfsr[2:0]] = '0;
				end
			end
			m_hit = hit_n;
			if (m_tick[1] && st_old == dodge_pkg::st_play)
			begin
				if (left)
					m_col = (m_col == 3'd0) ? m_col : m_col - 3'd1;
				else if (right)
					m_col = (m_col == 3'd7) ? m_col : m_col + 3'd1;
			end
			for (int i = 0; i < 4; i++)
			begin
				m_tick[i] = (m_cnt[i] == DIV[i] - 1);
				m_cnt[i] = m_tick[i] ? 0 : m_cnt[i] + 1;
			end
		end
	end

	//////////////////////////////////////////////////
	// checks

	function automatic logic [2:0] expected_light(input int life);
		if (life == 0)
			return 3'b000;
		if (life >= int'(dodge_pkg::LIFE_HIGH))
			return 3'b111;
		if (life >= int'(dodge_pkg::LIFE_MID))
			return 3'b011;
		return 3'b001;
	endfunction

	function automatic int dot_column(input logic [7:0] bits);
		for (int c = 0; c < 8; c++)
			if (!bits[c])
				return c;
		return -1;
	endfunction

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cycle();
		check_val("row_sel", row_sel, m_rsel);
		check_val("data_r", data_r, m_dr);
		check_val("data_b", data_b, m_db);
		check_val("elapsed_sec", elapsed_sec, 8'(m_sec));
		check_val("light", light, expected_light(m_life));
		if (m_state == dodge_pkg::st_play && row_sel == 3'd7)
			dot = dot_column(data_b);
	endtask

	task automatic check_picture(input dodge_pkg::game_state_t pic);
		if (pic == dodge_pkg::st_won)
		begin
			check_val("data_r", data_r, dodge_pkg::WIN_PIC[row_sel]);
			check_val("data_b", data_b, dodge_pkg::WIN_PIC[row_sel]);
			check_val("elapsed_sec", elapsed_sec, 8'(dodge_pkg::WIN_SECONDS));
		end
		else
		begin
			check_val("data_r", data_r, dodge_pkg::LOSS_PIC[row_sel]);
			check_val("data_b", data_b, 8'hff);
			check_val("light", light, 8'h00);
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus

	task automatic add_step(input int kind, input logic l, input logic r, input int hold,
		input int col, input dodge_pkg::game_state_t pic);
		steps.push_back('{kind, l, r, hold, col, pic});
	endtask

	// column of the lowest falling item
	function automatic int chase_target();
		int best;
		best = -1;
		for (int c = 0; c < 8; c++)
			if (m_act[c] && (best < 0 || m_row[c] >= m_row[best]))
				best = c;
		return (best < 0) ? int'(m_col) : best;
	endfunction

	// nearest column without an item close to the bottom
	function automatic int safe_target();
		int p;
		p = int'(m_col);
		for (int d = 0; d < 8; d++)
		begin
			if (p - d >= 0 && (!m_act[p - d] || m_row[p - d] < 3'd4))
				return p - d;
			if (p + d <= 7 && (!m_act[p + d] || m_row[p + d] < 3'd4))
				return p + d;
		end
		return p;
	endfunction

	task automatic drive_cycles(input logic l, input logic r, input int n,
		input dodge_pkg::game_state_t pic);
		left = l;
		right = r;
		for (int k = 0; k < n; k++)
		begin
			@(negedge CLK);
			check_cycle();
			if (pic != dodge_pkg::st_play && k >= 4) // next scanned row shows it
				check_picture(pic);
		end
		@(posedge CLK);
		#1;
	endtask

	task automatic run_step(input int i);
		step_t s;
		int err0;
		int used;
		int dir;
		s = steps[i];
		err0 = errors;
		dot = -1;
		case (s.kind)
			K_FIX: drive_cycles(s.l, s.r, s.hold, s.pic);
			K_RAND:
				for (used = 0; used < s.hold; used += 4)
				begin
					dir = $urandom % 3;
					drive_cycles(dir == 1, dir == 2, 4, dodge_pkg::st_play);
				end
			K_RST:
			begin
				reset = 1'b1;
				drive_cycles(1'b0, 1'b0, s.hold, dodge_pkg::st_play);
				reset = 1'b0;
			end
			default:
			begin
				for (used = 0; used < s.hold && m_state == dodge_pkg::st_play; used += 4)
				begin
					dir = (s.kind == K_CHASE) ? chase_target() : safe_target();
					dir = dir - int'(m_col);
					drive_cycles(dir < 0, dir > 0, 4, dodge_pkg::st_play);
				end
				left = 1'b0;
				right = 1'b0;
				assert (m_state == s.pic)
				else
				begin
					$display("test %0d: the game did not end as expected", i);
					errors++;
				end
			end
		endcase
		if (s.col >= 0)
			check_val("player column", 8'(dot), 8'(s.col));
		$display("test %0d %s: %0d errors", i, kind_names[s.kind], errors - err0);
	endtask

	initial
	begin
		int total;
		reset = 1'b1;
		left = 1'b0;
		right = 1'b0;
		void'($urandom(32'h5617_0dc1));
		add_step(K_FIX, 0, 0, 24, 0, dodge_pkg::st_play);
		add_step(K_FIX, 1, 0, 24, 0, dodge_pkg::st_play); // left edge
		add_step(K_FIX, 0, 1, 4, -1, dodge_pkg::st_play); // one move tick
		add_step(K_FIX, 0, 0, 24, 1, dodge_pkg::st_play);
		add_step(K_FIX, 0, 1, 48, 7, dodge_pkg::st_play);
		add_step(K_FIX, 1, 0, 4, -1, dodge_pkg::st_play);
		add_step(K_FIX, 0, 0, 24, 6, dodge_pkg::st_play);
		add_step(K_FIX, 1, 0, 48, 0, dodge_pkg::st_play);
		add_step(K_RAND, 0, 0, 400, -1, dodge_pkg::st_play);
		add_step(K_CHASE, 0, 0, 3200, -1, dodge_pkg::st_lost);
		add_step(K_FIX, 1, 0, 24, -1, dodge_pkg::st_lost);
		add_step(K_FIX, 0, 1, 24, -1, dodge_pkg::st_lost);
		add_step(K_RST, 0, 0, 16, -1, dodge_pkg::st_play);
		add_step(K_DODGE, 0, 0, 4400, -1, dodge_pkg::st_won);
		add_step(K_FIX, 0, 0, 24, -1, dodge_pkg::st_won);
		total = 16 + 256; // reset and margin
		foreach (steps[i])
			total += steps[i].hold;
		fork
			begin
				#(total * 8);
				$display("watchdog: run not finished after %0d cycles", total);
				$display("Verification failed");
				$finish;
			end
		join_none
		repeat (16) @(posedge CLK);
		#1;
		reset = 1'b0;
		foreach (steps[i])
			run_step(i);
		$display("tests %0d, checks %0d, errors %0d", steps.size(), checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: hw/dodge_game_top.sv
`timescale 1ns/1ns

module dodge_game_top #(
	parameter int SCAN_DIV = 50000,
	parameter int MOVE_DIV = 4000000,
	parameter int DROP_DIV = 12500000,
	parameter int SEC_DIV = 50000000
) (
	input logic CLK,
	input logic reset,
	input logic left,
	input logic right,
	output logic [2:0] row_sel,
	output logic [7:0] data_r,
	output logic [7:0] data_b,
	output logic [5:0] elapsed_sec,
	output logic [2:0] light
);

	logic scan_tick;
	logic move_tick;
	logic drop_tick;
	logic second_tick;
	logic hit;

	playfield_if pf ();

	game_tick_gen #(
		.SCAN_DIV(SCAN_DIV),
		.MOVE_DIV(MOVE_DIV),
		.DROP_DIV(DROP_DIV),
		.SEC_DIV(SEC_DIV)
	) i_tick_gen (
		.CLK(CLK),
		.reset(reset),
		.scan_tick(scan_tick),
		.move_tick(move_tick),
		.drop_tick(drop_tick),
		.second_tick(second_tick)
	);

	player_ctrl i_player_ctrl (
		.CLK(CLK),
		.reset(reset),
		.move_tick(move_tick),
		.left(left),
		.right(right),
		.pf(pf.source)
	);

	drop_field i_drop_field (
		.CLK(CLK),
		.reset(reset),
		.drop_tick(drop_tick),
		.pf(pf.source),
		.hit(hit)
	);

	game_fsm i_game_fsm (
		.CLK(CLK),
		.reset(reset),
		.hit(hit),
		.second_tick(second_tick),
		.pf(pf.source),
		.elapsed_sec(elapsed_sec),
		.light(light)
	);

	matrix_scan i_matrix_scan (
		.CLK(CLK),
		.reset(reset),
		.scan_tick(scan_tick),
		.pf(pf.scan),
		.row_sel(row_sel),
		.data_r(data_r),
		.data_b(data_b)
	);

endmodule

// File: hw/dodge_pkg.sv
package dodge_pkg;

	typedef logic [2:0] col_t;
	typedef logic [2:0] row_t; // also the drop height of an item
	typedef logic [7:0] row_bits_t; // active low, bit c is column c
	typedef logic [3:0] life_t;
	typedef logic [5:0] sec_t;
	typedef logic [2:0] lights_t;
	typedef logic [7:0] rnd_t;

	typedef enum logic [1:0] {
		st_play,
		st_won,
		st_lost
	} game_state_t;

	//////////////////////////////////////////////////
	// game constants

	localparam int NUM_COLS = 8;
	localparam row_t PLAYER_ROW = 3'd7;
	localparam life_t LIFE_INIT = 4'd6;
	localparam life_t LIFE_HIGH = 4'd4;
	localparam life_t LIFE_MID = 4'd2;
	localparam sec_t WIN_SECONDS = 6'd60;
	localparam rnd_t RND_SEED = 8'hA5;
	localparam rnd_t LFSR_TAPS = 8'hB8; // x^8+x^6+x^5+x^4+1, shifting right

	//////////////////////////////////////////////////
	// pictures, index is the row

	localparam row_bits_t WIN_PIC [NUM_COLS] = '{
		8'b11000011,
		8'b10111101,
		8'b01111110,
		8'b01111110,
		8'b01111110,
		8'b01111110,
		8'b10111101,
		8'b11000011
	};

	localparam row_bits_t LOSS_PIC [NUM_COLS] = '{
		8'b01111110,
		8'b10111101,
		8'b11011011,
		8'b11100111,
		8'b11100111,
		8'b11011011,
		8'b10111101,
		8'b01111110
	};

endpackage

// File: hw/drop_field.sv
`timescale 1ns/1ns

module drop_field (
	input logic CLK,
	input logic reset,
	input logic drop_tick,
	playfield_if.source pf,
	output logic hit
);

	dodge_pkg::rnd_t lfsr;
	dodge_pkg::rnd_t lfsr_nxt;
	logic [dodge_pkg::NUM_COLS-1:0] act_nxt;
	dodge_pkg::row_t row_nxt [dodge_pkg::NUM_COLS];
	logic hit_nxt;
	logic step;

	assign step = drop_tick && pf.state == dodge_pkg::st_play;

	//////////////////////////////////////////////////
	// next field

	always_comb
	begin
		act_nxt = pf.item_active;
		row_nxt = pf.item_row;
		hit_nxt = 1'b0;

		for (int c = 0; c < dodge_pkg::NUM_COLS; c++)
		begin
			if (pf.item_active[c])
			begin
				if (pf.item_row[c] == dodge_pkg::PLAYER_ROW)
				begin
					act_nxt[c] = 1'b0; // leaves the bottom
					if (pf.player_col == dodge_pkg::col_t'(c))
						hit_nxt = 1'b1;
				end
				else
					row_nxt[c] = pf.item_row[c] + 3'd1;
			end
		end

		lfsr_nxt = {1'b0, lfsr[7:1]} ^ (lfsr[0] ? dodge_pkg::LFSR_TAPS : 8'h00);

		// spawn sees the field after this step's fall and removal
		if (lfsr_nxt[7:6] == 2'b11 && !act_nxt[lfsr_nxt[2:0]])
		begin
			act_nxt[lfsr_nxt[2:0]] = 1'b1;
			row_nxt[lfsr_nxt[2:0]] = '0;
		end
	end

	//////////////////////////////////////////////////
	// registers

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			pf.item_active <= '0;
			lfsr <= dodge_pkg::RND_SEED;
			hit <= 1'b0;
		end
		else
		begin
			hit <= step && hit_nxt;
			if (step)
			begin
				pf.item_active <= act_nxt;
				lfsr <= lfsr_nxt;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (step)
			pf.item_row <= row_nxt;
	end

	a_hit_after_drop: assert property (@(posedge CLK) disable iff (reset)
		hit |-> $past(drop_tick));

endmodule

// File: hw/game_fsm.sv
`timescale 1ns/1ns

module game_fsm (
	input logic CLK,
	input logic reset,
	input logic hit,
	input logic second_tick,
	playfield_if.source pf,
	output dodge_pkg::sec_t elapsed_sec,
	output dodge_pkg::lights_t light
);

	dodge_pkg::life_t life;
	logic last_life;
	logic last_sec;

	assign last_life = hit && life == 4'd1;
	assign last_sec = second_tick && elapsed_sec == dodge_pkg::WIN_SECONDS - 6'd1;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			pf.state <= dodge_pkg::st_play;
			life <= dodge_pkg::LIFE_INIT;
			elapsed_sec <= '0;
		end
		else if (pf.state == dodge_pkg::st_play)
		begin
			if (hit)
				life <= life - 4'd1;
			if (second_tick)
				elapsed_sec <= elapsed_sec + 6'd1;

			if (last_life)
				pf.state <= dodge_pkg::st_lost; // loss beats a win on the same cycle
			else if (last_sec)
				pf.state <= dodge_pkg::st_won;
		end
	end

	// life lights
	always_comb
	begin
		if (life == 4'd0)
			light = 3'b000;
		else if (life >= dodge_pkg::LIFE_HIGH)
			light = 3'b111;
		else if (life >= dodge_pkg::LIFE_MID)
			light = 3'b011;
		else
			light = 3'b001;
	end

	a_end_is_final: assert property (@(posedge CLK) disable iff (reset)
		(pf.state != dodge_pkg::st_play) |=> (pf.state == $past(pf.state)));

endmodule

// File: hw/game_tick_gen.sv
`timescale 1ns/1ns

module game_tick_gen #(
	parameter int SCAN_DIV = 50000,
	parameter int MOVE_DIV = 4000000,
	parameter int DROP_DIV = 12500000,
	parameter int SEC_DIV = 50000000
) (
	input logic CLK,
	input logic reset,
	output logic scan_tick,
	output logic move_tick,
	output logic drop_tick,
	output logic second_tick
);

	logic [3:0] ticks;

	for (genvar i = 0; i < 4; i++)
	begin : g_div
		localparam int DIV = (i == 0) ? SCAN_DIV :
			(i == 1) ? MOVE_DIV :
			(i == 2) ? DROP_DIV : SEC_DIV;
		localparam int W = $clog2(DIV + 1);

		logic [W-1:0] cnt;
		logic tick;

		always_ff @(posedge CLK)
		begin
			if (reset)
			begin
				cnt <= '0;
				tick <= 1'b0;
			end
			else if (cnt == W'(DIV - 1))
			begin
				cnt <= '0;
				tick <= 1'b1; // wrap
			end
			else
			begin
				cnt <= cnt + 1'b1;
				tick <= 1'b0;
			end
		end

		assign ticks[i] = tick;

		// a divider of 1 is a steady enable
		if (DIV > 1)
		begin : g_chk
			a_one_cycle: assert property (@(posedge CLK) disable iff (reset)
				tick |=> !tick);
		end
	end

	assign scan_tick = ticks[0];
	assign move_tick = ticks[1];
	assign drop_tick = ticks[2];
	assign second_tick = ticks[3];

endmodule

// File: hw/matrix_scan.sv
`timescale 1ns/1ns

module matrix_scan (
	input logic CLK,
	input logic reset,
	input logic scan_tick,
	playfield_if.scan pf,
	output dodge_pkg::row_t row_sel,
	output dodge_pkg::row_bits_t data_r,
	output dodge_pkg::row_bits_t data_b
);

	dodge_pkg::row_t row_n;
	dodge_pkg::row_bits_t r_n;
	dodge_pkg::row_bits_t b_n;

	assign row_n = row_sel + 3'd1;

	// data for the row that comes next
	always_comb
	begin
		r_n = '1;
		b_n = '1;
		case (pf.state)
			dodge_pkg::st_play:
			begin
				for (int c = 0; c < dodge_pkg::NUM_COLS; c++)
				begin
					if (pf.item_active[c] && pf.item_row[c] == row_n)
						r_n[c] = 1'b0;
				end
				if (row_n == dodge_pkg::PLAYER_ROW)
					b_n[pf.player_col] = 1'b0; // player dot
			end
			dodge_pkg::st_won:
			begin
				r_n = dodge_pkg::WIN_PIC[row_n];
				b_n = dodge_pkg::WIN_PIC[row_n];
			end
			dodge_pkg::st_lost:
				r_n = dodge_pkg::LOSS_PIC[row_n];
			default:
			begin
				r_n = '1;
				b_n = '1;
			end
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			row_sel <= '0;
			data_r <= '1;
			data_b <= '1;
		end
		else if (scan_tick)
		begin
			row_sel <= row_n;
			data_r <= r_n;
			data_b <= b_n;
		end
	end

endmodule

// File: hw/player_ctrl.sv
`timescale 1ns/1ns

module player_ctrl (
	input logic CLK,
	input logic reset,
	input logic move_tick,
	input logic left,
	input logic right,
	playfield_if.source pf
);

	always_ff @(posedge CLK)
	begin
		if (reset)
			pf.player_col <= '0;
		else if (move_tick && pf.state == dodge_pkg::st_play)
		begin
			if (left)
			begin
				if (pf.player_col != 3'd0)
					pf.player_col <= pf.player_col - 3'd1;
			end
			else if (right)
			begin
				if (pf.player_col != 3'd7)
					pf.player_col <= pf.player_col + 3'd1; // stops at the right edge
			end
		end
	end

	a_col_moves_on_tick: assert property (@(posedge CLK) disable iff (reset)
		(!$past(move_tick) && !$past(reset)) |-> $stable(pf.player_col));

endmodule

// File: hw/playfield_if.sv
`timescale 1ns/1ns

interface playfield_if;

	dodge_pkg::col_t player_col;
	logic [dodge_pkg::NUM_COLS-1:0] item_active; // one per column
	dodge_pkg::row_t item_row [dodge_pkg::NUM_COLS];
	dodge_pkg::game_state_t state;

	// shared by player_ctrl, drop_field and game_fsm, each drives its own part
	modport source (
		output player_col,
		output item_active,
		output item_row,
		output state
	);

	modport scan (
		input player_col,
		input item_active,
		input item_row,
		input state
	);

endinterface
